// File: common/mio_consts.svh
//########################################
// mio link constants
// pad width, packet width and beat count
//########################################

`ifndef MIO_CONSTS_SVH
`define MIO_CONSTS_SVH

// pad bus width in bits (8, 16 or 32)
`define MIO_NMIO 16

// core packet width
// must be a multiple of twice the pad width
`define MIO_PW 128

// one beat is two pad words
`define MIO_NBEATS (`MIO_PW / (2 * `MIO_NMIO))

`endif

// File: common/mio_data_pkg.sv
//########################################
// mio data path types
// pad words, beats and core packets
//########################################

`include "mio_consts.svh"

package mio_data_pkg;

   //########################################
   // vector types
   //########################################

   // one word on the pad bus
   typedef logic [`MIO_NMIO-1:0] io_word_t;

   // one beat, two pad words
   // handed from shifter to io block
   typedef logic [2*`MIO_NMIO-1:0] io_beat_t;

   // full packet from the core
   typedef logic [`MIO_PW-1:0] packet_t;

endpackage

// File: common/mio_ctrl_pkg.sv
//########################################
// mio transmit control types
// static config, fsm states, beat count
//########################################

`include "mio_consts.svh"

package mio_ctrl_pkg;

   // static link configuration
   typedef struct packed {
      // send each beat on both clock phases
      logic ddr_mode;
      // low half and low beats go first
      logic lsbfirst;
   } mtx_cfg_t;

   // transmit fsm
   typedef enum logic {
      // waiting for the core
      MTX_IDLE = 1'b0,
      // moving beats to the io block
      MTX_SEND = 1'b1
   } mtx_state_t;

   // wide enough to hold the full beat count
   localparam int BEAT_CNT_W = $clog2(`MIO_NBEATS + 1);
   typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

endpackage

// File: mtx/mtx_ctrl.sv
//########################################
// transmit control fsm
// accepts a packet, steers shifter, releases core
//########################################

`include "mio_consts.svh"

module mtx_ctrl (
   // clock and async reset
   input  logic io_clk,
   input  logic io_nreset,
   // core request level
   input  logic access,
   // pushback from io block
   input  logic io_wait,
   // current beat is the final one
   input  logic last_beat,
   // core held off while sending
   output logic core_wait,
   // capture packet and restart count
   output logic load,
   // move on to next beat
   output logic advance,
   // a beat is on offer to the io block
   output logic beat_valid
);

   import mio_ctrl_pkg::*;

   mtx_state_t state_q;
   mtx_state_t state_d;

   //########################################
   // next state
   //########################################

   always_comb begin
      state_d = state_q;
      case (state_q)
         MTX_IDLE: begin
            // core_wait is low here so access alone takes the packet
            if (access) begin
               state_d = MTX_SEND;
            end
         end
         MTX_SEND: begin
            // leave on the edge the final beat moves on
            if (advance && last_beat) begin
               state_d = MTX_IDLE;
            end
         end
         default: begin
            state_d = MTX_IDLE;
         end
      endcase
   end

   // state register
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         state_q <= MTX_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   //########################################
   // outputs
   //########################################

   // capture strobe on the accept edge
   assign load = (state_q == MTX_IDLE) & access;

   // beat on offer for the whole send phase
   assign beat_valid = (state_q == MTX_SEND);

   // core stays blocked until the last beat leaves
   assign core_wait = (state_q == MTX_SEND);

   // step only when io block takes the beat
   assign advance = beat_valid & ~io_wait;

endmodule

// File: mtx/mtx_beat_count.sv
//########################################
// beat counter
// counts beats left in the current packet
//########################################

`include "mio_consts.svh"

module mtx_beat_count (
   // clock and async reset
   input  logic io_clk,
   input  logic io_nreset,
   // start of a new packet
   input  logic load,
   // one beat taken
   input  logic advance,
   // current beat is the last one
   output logic last_beat
);

   import mio_ctrl_pkg::*;

   // beats still to go, current one included
   beat_cnt_t cnt_q;

   //########################################
   // down counter
   //########################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         cnt_q <= '0;
      end else if (load) begin
         // full packet ahead
         cnt_q <= beat_cnt_t'(`MIO_NBEATS);
      end else if (advance) begin
         cnt_q <= cnt_q - beat_cnt_t'(1);
      end
   end

   // one beat left
   // controller needs no width knowledge
   assign last_beat = (cnt_q == beat_cnt_t'(1));

endmodule

// File: mtx/mtx_shift.sv
//########################################
// packet shift register
// holds the packet, presents the next beat
//########################################

`include "mio_consts.svh"

module mtx_shift (
   // clock and async reset
   input  logic                  io_clk,
   input  logic                  io_nreset,
   // static link config
   input  mio_ctrl_pkg::mtx_cfg_t cfg,
   // capture a new packet
   input  logic                  load,
   // drop the current beat
   input  logic                  advance,
   // packet from the core
   input  mio_data_pkg::packet_t packet,
   // beat for the io block
   output mio_data_pkg::io_beat_t beat
);

   import mio_data_pkg::*;

   // beat width in bits
   localparam int BW = 2 * `MIO_NMIO;

   // packet held while it goes out
   packet_t pkt_q;

   //########################################
   // shift register
   //########################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         pkt_q <= '0;
      end else if (load) begin
         pkt_q <= packet;
      end else if (advance) begin
         // lsb first drains from the bottom
         if (cfg.lsbfirst) begin
            pkt_q <= pkt_q >> BW;
         end else begin
            // msb first drains from the top
            pkt_q <= pkt_q << BW;
         end
      end
   end

   //########################################
   // beat select
   //########################################

   // slice on the side the register drains from
   assign beat = cfg.lsbfirst ? pkt_q[BW-1:0] : pkt_q[`MIO_PW-1 -: BW];

endmodule

// File: mtx/mtx_io.sv
//########################################
// transmit io timing block
// reset sync, sdr half select, ddr output
//########################################

`include "mio_consts.svh"

module mtx_io (
   // clock and async reset
   input  logic                   io_clk,
   input  logic                   io_nreset,
   // static link config
   input  mio_ctrl_pkg::mtx_cfg_t  cfg,
   // beat on offer
   input  logic                   io_access,
   // beat from the shifter
   input  mio_data_pkg::io_beat_t beat,
   // pad side pushback
   input  logic                   tx_wait,
   // pushback to the controller
   output logic                   io_wait,
   // pad side
   output logic                   tx_access,
   output mio_data_pkg::io_word_t tx_packet
);

   import mio_data_pkg::*;

   logic [1:0] rst_sync_q;
   logic       io_nreset_sync;
   // 1 once the first half of an sdr beat went out
   logic       second_sel_q;
   logic       half_pend;
   logic       take;
   io_word_t   first_half;
   io_word_t   second_half;
   io_word_t   sdr_word_q;
   io_word_t   ddr_hi_q;
   io_word_t   ddr_lo_q;

   //########################################
   // reset synchronizer
   //########################################

   // async assert, two-flop release
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         rst_sync_q <= 2'b00;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};
      end
   end

   assign io_nreset_sync = rst_sync_q[1];

   //########################################
   // access and half select
   //########################################

   // a word leaves on this edge
   assign take = io_access & ~tx_wait;

   // pad strobe drops for any cycle the pads stall
   always_ff @(posedge io_clk or negedge io_nreset_sync) begin
      if (!io_nreset_sync) begin
         tx_access    <= 1'b0;
         second_sel_q <= 1'b0;
      end else begin
         tx_access <= take;
         // toggles once per word in sdr, holds under tx_wait
         if (take && !cfg.ddr_mode) begin
            second_sel_q <= ~second_sel_q;
         end
      end
   end

   // sdr beat still owes its second half
   assign half_pend = ~cfg.ddr_mode & ~second_sel_q;

   assign io_wait = tx_wait | half_pend;

   //########################################
   // data ordering
   //########################################

   // lsbfirst sends the low half first
   assign first_half  = cfg.lsbfirst ? beat[`MIO_NMIO-1:0] : beat[2*`MIO_NMIO-1:`MIO_NMIO];
   assign second_half = cfg.lsbfirst ? beat[2*`MIO_NMIO-1:`MIO_NMIO] : beat[`MIO_NMIO-1:0];

   //########################################
   // sdr and ddr data registers
   //########################################

   always_ff @(posedge io_clk) begin
      if (take) begin
         // one half per cycle
         sdr_word_q <= second_sel_q ? second_half : first_half;
         // both halves at once for ddr
         ddr_hi_q   <= first_half;
         ddr_lo_q   <= second_half;
      end
   end

   // ddr sends the first half while io_clk is high and the second half while low
   assign tx_packet = cfg.ddr_mode ? (io_clk ? ddr_hi_q : ddr_lo_q) : sdr_word_q;

endmodule

// File: src/mtx_top.sv
//########################################
// mio transmit subsystem
// core packet in, narrow pad words out
//########################################

`include "mio_consts.svh"

module mtx_top (
   // clock and async reset
   input  logic                   io_clk,
   input  logic                   io_nreset,
   // static link config
   input  mio_ctrl_pkg::mtx_cfg_t  cfg,
   // core port
   input  logic                   access,
   input  mio_data_pkg::packet_t  packet,
   output logic                   core_wait,
   // pad port
   input  logic                   tx_wait,
   output logic                   tx_access,
   output mio_data_pkg::io_word_t tx_packet
);

   import mio_data_pkg::*;

   // control to data path
   logic     load;
   logic     advance;
   logic     beat_valid;
   logic     last_beat;
   // io block pushback
   logic     io_wait;
   // current beat
   io_beat_t beat;

   //########################################
   // control
   //########################################

   mtx_ctrl u_ctrl (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .access     (access),
      .io_wait    (io_wait),
      .last_beat  (last_beat),
      .core_wait  (core_wait),
      .load       (load),
      .advance    (advance),
      .beat_valid (beat_valid)
   );

   mtx_beat_count u_beat_count (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .load      (load),
      .advance   (advance),
      .last_beat (last_beat)
   );

   //########################################
   // data path
   //########################################

   mtx_shift u_shift (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .cfg       (cfg),
      .load      (load),
      .advance   (advance),
      .packet    (packet),
      .beat      (beat)
   );

   // pad timing
   mtx_io u_io (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .cfg       (cfg),
      .io_access (beat_valid),
      .beat      (beat),
      .tx_wait   (tx_wait),
      .io_wait   (io_wait),
      .tx_access (tx_access),
      .tx_packet (tx_packet)
   );

endmodule

// File: test/mtx_tb.sv
//########################################
// mtx_top testbench
// table of packets, word monitor, checks
//########################################

`include "mio_consts.svh"

module mtx_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import mio_data_pkg::*;
   import mio_ctrl_pkg::*;

   localparam int NENT    = 10;
   localparam int NWORDS  = 2 * `MIO_NBEATS;
   // longest average tx_wait stretch allowed for
   localparam int STRETCH = 8;
   localparam int LIMIT   = NENT * NWORDS * STRETCH + NENT * 8 + 16 + 200;

   logic       io_clk;
   logic       io_nreset;
   mtx_cfg_t   cfg;
   logic       access;
   packet_t    packet;
   logic       core_wait;
   logic       tx_wait;
   logic       tx_access;
   io_word_t   tx_packet;

   // stimulus table
   mtx_cfg_t   tab_cfg [NENT];
   packet_t    tab_pkt [NENT];
   int         tab_wait [NENT];
   int         tab_gap [NENT];

   io_word_t   exp_q[$];
   logic [16:0] lfsr_q = 17'd79714;
   int         wait_mode = 0;
   int         acc_cycles = 0;
   int         cycle_cnt = 0;

   mtx_top UUT (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .cfg       (cfg),
      .access    (access),
      .packet    (packet),
      .core_wait (core_wait),
      .tx_wait   (tx_wait),
      .tx_access (tx_access),
      .tx_packet (tx_packet)
   );

   always #5 io_clk = ~io_clk;

   //########################################
   // helpers
   //########################################

   // x^17 + x^14 + 1
   function automatic logic [16:0] lfsr_step(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   function automatic logic rand_bit();
      logic b;
      b = lfsr_q[16];
      lfsr_q = lfsr_step(lfsr_q);
      return b;
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string sig, input io_word_t got, input io_word_t exp);
      if (got !== exp) begin
         fail_stop($sformatf("ERR %s got %h exp %h", sig, got, exp));
      end
   endtask

   task automatic check_flag(input string sig, input logic got, input logic exp);
      if (got !== exp) begin
         fail_stop($sformatf("ERR %s got %h exp %h", sig, got, exp));
      end
   endtask

   task automatic check_count(input string sig, input int got, input int exp);
      if (got != exp) begin
         fail_stop($sformatf("ERR %s got %h exp %h", sig, got, exp));
      end
   endtask

   task automatic add_entry(input int i, input logic ddr, input logic lsb,
                            input int w, input int g);
      tab_cfg[i].ddr_mode = ddr;
      tab_cfg[i].lsbfirst = lsb;
      tab_wait[i] = w;
      tab_gap[i] = g;
      // one lfsr step per packet bit
      for (int b = 0; b < `MIO_PW; b++) begin
         tab_pkt[i][b] = rand_bit();
      end
   endtask

   // pad word against the head of the expected queue
   task automatic record_word(input io_word_t w);
      if (exp_q.size() == 0) begin
         fail_stop("a pad word came out with no word expected");
      end
      check_word("tx_packet", w, exp_q.pop_front());
   endtask

   //########################################
   // pad monitor, tx_wait, timeout
   //########################################

   // sdr word held for a full cycle
   always @(posedge io_clk) begin
      if (tx_access && !cfg.ddr_mode) begin
         record_word(tx_packet);
      end
      if (tx_access) begin
         acc_cycles++;
      end
   end

   // ddr high phase carries the first half
   always @(posedge io_clk) begin
      #2.5;
      if (tx_access && cfg.ddr_mode) begin
         record_word(tx_packet);
      end
   end

   always @(negedge io_clk) begin
      #2.5;
      if (tx_access && cfg.ddr_mode) begin
         record_word(tx_packet);
      end
   end

   // mode 1 about a quarter high, mode 2 about three quarters
   always @(posedge io_clk) begin : wait_gen
      logic b0;
      logic b1;
      b0 = rand_bit();
      b1 = rand_bit();
      case (wait_mode)
         1: tx_wait <= b0 & b1;
         2: tx_wait <= b0 | b1;
         default: tx_wait <= 1'b0;
      endcase
   end

   always @(posedge io_clk) begin
      cycle_cnt++;
      if (cycle_cnt > LIMIT) begin
         fail_stop("timeout, the packets did not finish in time");
      end
   end

   //########################################
   // main sequence
   //########################################

   initial begin
      int idx;
      int cw;
      logic taken;
      io_clk = 1'b0;
      io_nreset = 1'b0;
      cfg = '0;
      access = 1'b0;
      packet = '0;
      tx_wait = 1'b0;
      // sdr/ddr, both orders, quiet and busy pads
      add_entry(0, 1'b0, 1'b1, 0, 2);
      add_entry(1, 1'b0, 1'b0, 0, 0);
      add_entry(2, 1'b1, 1'b1, 0, 3);
      add_entry(3, 1'b1, 1'b0, 0, 0);
      add_entry(4, 1'b0, 1'b1, 1, 1);
      add_entry(5, 1'b0, 1'b0, 2, 0);
      add_entry(6, 1'b1, 1'b1, 1, 2);
      add_entry(7, 1'b1, 1'b0, 2, 0);
      add_entry(8, 1'b0, 1'b1, 0, 0);
      add_entry(9, 1'b1, 1'b1, 2, 0);

      repeat (16) @(posedge io_clk);
      io_nreset <= 1'b1;
      repeat (3) @(posedge io_clk);
      check_flag("core_wait", core_wait, 1'b0);
      check_flag("tx_access", tx_access, 1'b0);

      for (int e = 0; e < NENT; e++) begin
         repeat (tab_gap[e]) @(posedge io_clk);
         @(posedge io_clk);
         wait_mode = tab_wait[e];
         cfg <= tab_cfg[e];
         packet <= tab_pkt[e];
         access <= 1'b1;
         // accept edge has access high and core_wait low
         taken = 1'b0;
         while (!taken) begin
            @(posedge io_clk);
            taken = !core_wait;
         end
         access <= 1'b0;
         for (int k = 0; k < NWORDS; k++) begin
            idx = tab_cfg[e].lsbfirst ? k : NWORDS - 1 - k;
            exp_q.push_back(tab_pkt[e][idx*`MIO_NMIO +: `MIO_NMIO]);
         end
         // core held off for the whole send phase
         @(posedge io_clk);
         check_flag("core_wait", core_wait, 1'b1);
         cw = 1;
         while (core_wait) begin
            @(posedge io_clk);
            if (core_wait) begin
               cw++;
            end
         end
         if (tab_wait[e] == 0) begin
            check_count("core_wait cycles", cw, tab_cfg[e].ddr_mode ? NWORDS / 2 : NWORDS);
         end
         // core_wait low means the last beat moved on and its words are out
         @(negedge io_clk);
         check_count("pending words", exp_q.size(), 0);
         // ddr puts two words in each strobe cycle
         check_count("tx_access cycles", acc_cycles,
                     tab_cfg[e].ddr_mode ? NWORDS / 2 : NWORDS);
         check_flag("core_wait", core_wait, 1'b0);
         acc_cycles = 0;
      end
      wait_mode = 0;
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+common
common/mio_data_pkg.sv
common/mio_ctrl_pkg.sv
mtx/mtx_ctrl.sv
mtx/mtx_beat_count.sv
mtx/mtx_shift.sv
mtx/mtx_io.sv
src/mtx_top.sv
test/mtx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mtx testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f vlog.f --top-module mtx_tb -o Vmtx_tb; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vmtx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator returned status $status"
fi

if grep -q "TESTBENCH PASSED" sim.log; then
   exit 0
fi
exit 1
